// ==== flist.f ====
+incdir+logic
logic/flacStreamPkg.sv
logic/predictorPkg.sv
logic/predictorIf.sv
logic/subframeSequencer.sv
logic/fixedPredictor.sv
logic/subframeDecoder.sv
verification/clockGen.sv
verification/subframeDecoder_properties.sv
verification/subframeDecoderTb.sv

// ==== logic/fixedPredictor.sv ====
`include "flac_config.svh"

// rebuilds samples from residuals with a fixed polynomial predictor.
module fixedPredictor
    import predictorPkg::*;
(
    input  logic                            iClock,
    input  logic                            rstN,
    predictorIf.sink                        pred,
    output logic                            outValid,
    input  logic                            outReady,
    output logic signed [`SAMPLE_WIDTH-1:0] outSample,
    output logic                            outLast
);

    historyT                         history;    // last four outputs, newest first.
    orderT                           warmCountQ; // samples already passed this block.
    orderT                           warmCount;  // count seen by the current item.
    orderT                           effOrder;   // order after the range check.
    logic                            warmUp;     // current item passes unchanged.
    logic                            accept;
    logic signed [`SAMPLE_WIDTH-1:0] prediction;
    logic signed [`SAMPLE_WIDTH-1:0] result;

    // take a new item when the output register is free or being emptied.
    assign pred.ready = !outValid || outReady;
    assign accept     = pred.valid && pred.ready;

    assign effOrder  = (pred.order > orderT'(`MAX_ORDER)) ? '0 : pred.order;
    assign warmCount = pred.firstOfBlock ? '0 : warmCountQ; // a new block starts cold.
    assign warmUp    = (warmCount < effOrder);

    // ==================================================
    // prediction from the history.
    // ==================================================

    // binomial weights, built from shifts so every term stays 16 bits wide.
    // all sums wrap in two's complement like the stream format expects.
    always_comb begin
        case (effOrder)
            3'd1: prediction = history[0];
            3'd2: prediction = (history[0] <<< 1) - history[1];
            3'd3: begin
                prediction = (history[0] <<< 1) + history[0]
                           - (history[1] <<< 1) - history[1]
                           + history[2];
            end
            3'd4: begin
                prediction = (history[0] <<< 2)
                           - (history[1] <<< 2) - (history[1] <<< 1)
                           + (history[2] <<< 2)
                           - history[3];
            end
            default: prediction = '0; // order 0 adds nothing.
        endcase
    end

    // warm-up samples are sent verbatim.
    assign result = warmUp ? pred.residual : pred.residual + prediction;

    // ==================================================
    // output register and block bookkeeping.
    // ==================================================

    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            outValid   <= 1'b0;
            outLast    <= 1'b0;
            warmCountQ <= '0;
        end else begin
            if (accept) begin
                outValid <= 1'b1;
                outLast  <= pred.lastOfBlock;
                // stop counting once the order is reached.
                warmCountQ <= warmUp ? warmCount + 3'd1 : warmCount;
            end else if (outReady) begin
                outValid <= 1'b0; // the held item left and nothing replaced it.
                outLast  <= 1'b0;
            end
        end
    end

    // sample and history move together on every accepted item.
    always_ff @(posedge iClock) begin
        if (accept) begin
            outSample <= result;
            for (int i = `MAX_ORDER - 1; i > 0; i--) begin
                history[i] <= history[i - 1];
            end
            history[0] <= result;
        end
    end

endmodule

// ==== logic/flacStreamPkg.sv ====
`include "flac_config.svh"

// types that describe the incoming word stream.
package flacStreamPkg;

    // subframe kinds carried in the two top bits of a header word.
    typedef enum logic [1:0] {
        CONSTANT = 2'd0,    // one value word, repeated for the block.
        VERBATIM = 2'd1,    // raw samples, one word each.
        FIXED    = 2'd2     // residuals for a fixed polynomial predictor.
    } subframeKindT;

    // header layout, msb first.
    // kind and order take 5 bits and the block length fills the rest of the word.
    typedef struct packed {
        subframeKindT                kind;             // subframe kind.
        logic [2:0]                  order;            // predictor order for FIXED.
        logic [`BLOCK_LEN_WIDTH-1:0] blockLenMinusOne; // samples in the block, less one.
    } subframeHeaderT;

    // one stream word read two ways.
    // the sequencer picks the view from its state, so the same bits serve as
    // a header at a subframe boundary and as a signed value inside the block.
    typedef union packed {
        subframeHeaderT                  header;
        logic signed [`SAMPLE_WIDTH-1:0] value;
    } streamWordT;

endpackage

// ==== logic/flac_config.svh ====
`ifndef FLAC_CONFIG_SVH
`define FLAC_CONFIG_SVH

// ==================================================
// decoder dimensions.
// ==================================================

// width of a stream word, a residual and a decoded sample.
`define SAMPLE_WIDTH 16

// highest fixed predictor order that is decoded. Larger orders fall back to 0.
`define MAX_ORDER 4

// width of the blockLenMinusOne field in a subframe header.
`define BLOCK_LEN_WIDTH 11

`endif

// ==== logic/predictorIf.sv ====
`include "flac_config.svh"

// link from the word sequencer to the fixed predictor.
// one item moves on each rising edge where valid and ready are both high.
interface predictorIf
    import predictorPkg::*;
();

    logic                            valid;        // an item is on offer.
    logic                            ready;        // the predictor can take it.
    logic signed [`SAMPLE_WIDTH-1:0] residual;     // residual or raw sample.
    orderT                           order;        // order for this block.
    logic                            firstOfBlock; // item opens a block.
    logic                            lastOfBlock;  // item closes a block.

    // the sequencer side decides what is sent and where blocks begin and end.
    modport source (
        output valid, residual, order, firstOfBlock, lastOfBlock,
        input  ready
    );

    // the predictor side only pushes back.
    modport sink (
        input  valid, residual, order, firstOfBlock, lastOfBlock,
        output ready
    );

endinterface

// ==== logic/predictorPkg.sv ====
`include "flac_config.svh"

// types that describe the predictor side of the decoder.
package predictorPkg;

    // predictor order as carried on the internal link.
    // three bits reach 7, above MAX_ORDER, so the predictor must range check it.
    typedef logic [2:0] orderT;

    // past outputs of the predictor.
    // element 0 is the most recent sample and element MAX_ORDER-1 the oldest.
    typedef logic signed [`SAMPLE_WIDTH-1:0] historyT [`MAX_ORDER];

endpackage

// ==== logic/subframeDecoder.sv ====
`include "flac_config.svh"

// single-channel subframe decoder.
// words enter at the sequencer and samples leave from the predictor's register.
module subframeDecoder
    import flacStreamPkg::*;
(
    input  logic                            iClock,
    input  logic                            rstN,
    // word stream in.
    input  logic                            inValid,
    output logic                            inReady,
    input  streamWordT                      inWord,
    // sample stream out.
    output logic                            outValid,
    input  logic                            outReady,
    output logic signed [`SAMPLE_WIDTH-1:0] outSample,
    output logic                            outLast
);

    // ==================================================
    // sequencer to predictor link.
    // ==================================================

    predictorIf predLink ();

    subframeSequencer i_subframeSequencer (
        .iClock  (iClock),
        .rstN    (rstN),
        .inValid (inValid),
        .inReady (inReady),
        .inWord  (inWord),
        .pred    (predLink.source)
    );

    fixedPredictor i_fixedPredictor (
        .iClock    (iClock),
        .rstN      (rstN),
        .pred      (predLink.sink),
        .outValid  (outValid),
        .outReady  (outReady),
        .outSample (outSample),
        .outLast   (outLast)
    );

endmodule

// ==== logic/subframeSequencer.sv ====
`include "flac_config.svh"

// splits the word stream into subframes and feeds the predictor.
module subframeSequencer
    import flacStreamPkg::*;
    import predictorPkg::*;
(
    input  logic       iClock,
    input  logic       rstN,
    input  logic       inValid,
    output logic       inReady,
    input  streamWordT inWord,
    predictorIf.source pred
);

    typedef enum logic [1:0] {
        AWAIT_HEADER,   // next word is a subframe header.
        STREAMING,      // words pass straight to the predictor.
        REPEATING       // a captured constant is sent for the whole block.
    } seqStateT;

    seqStateT                        stateQ;
    logic [`BLOCK_LEN_WIDTH-1:0]     countQ;      // items still to send, less one.
    orderT                           orderQ;      // order sent with every item.
    logic                            firstQ;      // next item opens the block.
    logic                            valueHeldQ;  // the constant word is captured.
    logic signed [`SAMPLE_WIDTH-1:0] constValueQ; // value of a constant block.
    logic                            inFire;
    logic                            predFire;

    assign inFire   = inValid && inReady;
    assign predFire = pred.valid && pred.ready;

    // ==================================================
    // routing toward the predictor.
    // ==================================================

    always_comb begin
        inReady       = 1'b0;
        pred.valid    = 1'b0;
        pred.residual = inWord.value; // the word is read as a value here.
        case (stateQ)
            AWAIT_HEADER: inReady = 1'b1; // a header never stalls.
            STREAMING: begin
                // no storage here, so back-pressure goes straight through.
                pred.valid = inValid;
                inReady    = pred.ready;
            end
            REPEATING: begin
                // take the single value word first, then replay it.
                inReady       = !valueHeldQ;
                pred.valid    = valueHeldQ;
                pred.residual = constValueQ;
            end
            default: inReady = 1'b0;
        endcase
    end

    assign pred.order        = orderQ;
    assign pred.firstOfBlock = firstQ;
    assign pred.lastOfBlock  = (countQ == '0); // count is zero on the final item.

    // ==================================================
    // state and block counter.
    // ==================================================

    always_ff @(posedge iClock or negedge rstN) begin
        if (!rstN) begin
            stateQ     <= AWAIT_HEADER;
            countQ     <= '0;
            orderQ     <= '0;
            firstQ     <= 1'b0;
            valueHeldQ <= 1'b0;
        end else begin
            case (stateQ)
                AWAIT_HEADER: begin
                    if (inFire) begin
                        countQ     <= inWord.header.blockLenMinusOne;
                        firstQ     <= 1'b1;
                        valueHeldQ <= 1'b0;
                        case (inWord.header.kind)
                            CONSTANT: begin
                                stateQ <= REPEATING;
                                orderQ <= '0; // constant values are not predicted.
                            end
                            FIXED: begin
                                stateQ <= STREAMING;
                                orderQ <= inWord.header.order;
                            end
                            default: begin
                                stateQ <= STREAMING; // unknown kinds decode as verbatim.
                                orderQ <= '0;
                            end
                        endcase
                    end
                end
                STREAMING, REPEATING: begin
                    if (inFire) begin
                        valueHeldQ <= 1'b1; // only the constant word lands here.
                    end
                    if (predFire) begin
                        firstQ <= 1'b0;
                        if (countQ == '0) begin
                            stateQ <= AWAIT_HEADER;
                        end else begin
                            countQ <= countQ - 1'b1;
                        end
                    end
                end
                default: stateQ <= AWAIT_HEADER;
            endcase
        end
    end

    // the constant itself.
    always_ff @(posedge iClock) begin
        if (stateQ == REPEATING && inFire) begin
            constValueQ <= inWord.value;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# compiles the decoder and its testbench with Verilator and runs the simulation.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module subframeDecoderTb \
    -Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation stopped with status $simStatus"
    exit 1
fi

# the verdict comes from the log.
if grep -q "Testbench failed" "$logFile"; then
    exit 1
fi

exit 0

// ==== verification/clockGen.sv ====
// free running testbench clock with a power-on reset.
module clockGen #(
    parameter int period      = 10, // clock period in time units.
    parameter int resetCycles = 4   // rising edges seen while reset is held.
) (
    output logic iClock,
    output logic rstN
);

    initial begin
        iClock = 1'b0;
        forever #(period / 2) iClock = ~iClock;
    end

    // reset is let go on a falling edge, away from the edge the DUT samples on.
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge iClock);
        @(negedge iClock);
        rstN = 1'b1;
    end

endmodule

// ==== verification/subframeDecoderTb.sv ====
`include "flac_config.svh"

module subframeDecoderTb
    import flacStreamPkg::*;
    import predictorPkg::*;
();

    typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

    // well above the cycles that all tests take, stalls included.
    localparam int timeoutCycles = 4000;

    logic       iClock;
    logic       rstN;
    logic       inValid;
    logic       inReady;
    streamWordT inWord;
    logic       outValid;
    logic       outReady;
    sampleT     outSample;
    logic       outLast;

    integer seed      = 32'hf349_28cf; // residuals and raw words.
    integer stallSeed = 32'hf349_28cf; // output stalls, kept apart from the data.
    logic   stallEnable;
    int     cycleCount   = 0;
    int     sampleErrors = 0;
    int     lastErrors   = 0;
    int     countErrors  = 0;
    int     readyErrors  = 0;

    sampleT resWords [$];   // words of the block being built.
    sampleT expSamples [$]; // samples the model expects, in order.
    logic   expLast [$];
    sampleT gotSamples [$]; // samples the DUT handed out.
    logic   gotLast [$];

    clockGen #(.period(10), .resetCycles(4)) i_clockGen (.iClock(iClock), .rstN(rstN));

    subframeDecoder i_subframeDecoder (
        .iClock    (iClock),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inWord    (inWord),
        .outValid  (outValid),
        .outReady  (outReady),
        .outSample (outSample),
        .outLast   (outLast)
    );

    bind subframeDecoder subframeDecoderProperties i_subframeDecoderProperties (
        .iClock    (iClock),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inWord    (inWord),
        .outValid  (outValid),
        .outReady  (outReady),
        .outSample (outSample),
        .outLast   (outLast)
    );

    // ==================================================
    // stream helpers and the reference model.
    // ==================================================

    function automatic streamWordT makeHeader(input subframeKindT kind, input orderT order,
                                              input int len);
        streamWordT word;
        int         lenMinusOne;
        lenMinusOne = len - 1;
        word.header.kind             = kind;
        word.header.order            = order;
        word.header.blockLenMinusOne = lenMinusOne[`BLOCK_LEN_WIDTH-1:0];
        return word;
    endfunction

    function automatic streamWordT wordFromValue(input sampleT value);
        streamWordT word;
        word.value = value; // the same bits, seen as a sample.
        return word;
    endfunction

    // called on a falling edge and returns on the falling edge after the transfer.
    task automatic sendWord(input streamWordT word);
        inWord  = word;
        inValid = 1'b1;
        #1; // inReady settles once outReady for this cycle is driven.
        while (!inReady) begin
            @(negedge iClock);
            #1;
        end
        @(negedge iClock);
    endtask

    // span 0 gives full 16-bit words, otherwise values below span in size.
    task automatic fillResiduals(input int len, input int span);
        int r;
        resWords.delete();
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            if (span > 0) r = r % span;
            resWords.push_back(r[`SAMPLE_WIDTH-1:0]);
        end
    endtask

    // fixed prediction uses the binomial weights of the order, with 16-bit wrap.
    task automatic modelBlock(input subframeKindT kind, input orderT order, input int len);
        int     blk [$];
        int     eff;
        int     acc;
        sampleT sample;
        eff = (kind == FIXED && order <= 3'd4) ? int'(order) : 0;
        for (int i = 0; i < len; i++) begin
            if (kind == CONSTANT) begin
                acc = int'(resWords[0]);
            end else begin
                acc = int'(resWords[i]);
                if (i >= eff) begin // warm-up samples are the residual itself.
                    case (eff)
                        1: acc += blk[i-1];
                        2: acc += 2 * blk[i-1] - blk[i-2];
                        3: acc += 3 * blk[i-1] - 3 * blk[i-2] + blk[i-3];
                        4: acc += 4 * blk[i-1] - 6 * blk[i-2] + 4 * blk[i-3] - blk[i-4];
                        default: acc += 0;
                    endcase
                end
            end
            sample = acc[`SAMPLE_WIDTH-1:0]; // wrap to the sample width.
            blk.push_back(int'(sample));
            expSamples.push_back(sample);
            expLast.push_back(i == len - 1);
        end
    endtask

    task automatic sendBlock(input subframeKindT kind, input orderT order, input int len);
        sendWord(makeHeader(kind, order, len));
        if (kind == CONSTANT) begin
            sendWord(wordFromValue(resWords[0])); // one word for the whole block.
        end else begin
            for (int i = 0; i < len; i++) sendWord(wordFromValue(resWords[i]));
        end
        inValid = 1'b0;
        modelBlock(kind, order, len);
    endtask

    task automatic clearQueues();
        expSamples.delete();
        expLast.delete();
        gotSamples.delete();
        gotLast.delete();
    endtask

    // ==================================================
    // compare tasks.
    // ==================================================

    task automatic checkSample(input string testName, input int index, input sampleT expected,
                               input sampleT actual);
        if (actual !== expected) begin
            $display("ERR %s: sample %0d expected %0d, actual %0d",
                     testName, index, expected, actual);
            sampleErrors++;
        end
    endtask

    task automatic checkLast(input string testName, input int index, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: outLast of sample %0d expected %b, actual %b",
                     testName, index, expected, actual);
            lastErrors++;
        end
    endtask

    // waits for every expected sample, then a few cycles more to catch extras.
    task automatic collectAndCheck(input string testName);
        int n;
        n = expSamples.size();
        while (gotSamples.size() < n) @(negedge iClock);
        repeat (4) @(negedge iClock);
        if (gotSamples.size() != n) begin
            $display("%s: the DUT gave %0d samples where %0d were due",
                     testName, gotSamples.size(), n);
            countErrors++;
        end
        for (int i = 0; i < n && i < gotSamples.size(); i++) begin
            checkSample(testName, i, expSamples[i], gotSamples[i]);
            checkLast(testName, i, expLast[i], gotLast[i]);
        end
    endtask

    // ==================================================
    // directed tests.
    // ==================================================

    // the word input stays closed while the constant is replayed, one item per cycle.
    task automatic testConstant();
        int blockLen;
        int closedCycles;
        blockLen     = 8;
        closedCycles = 0;
        clearQueues();
        fillResiduals(1, 0);
        sendBlock(CONSTANT, 3'd0, blockLen);
        #1; // inReady is read once this cycle's inputs have settled.
        while (!inReady && closedCycles <= blockLen) begin
            closedCycles++;
            @(negedge iClock);
            #1;
        end
        if (closedCycles != blockLen) begin
            $display("constant: inReady stayed low for %0d cycles where %0d were due",
                     closedCycles, blockLen);
            readyErrors++;
        end
        collectAndCheck("constant");
    endtask

    task automatic testVerbatim();
        clearQueues();
        fillResiduals(16, 0);
        sendBlock(VERBATIM, 3'd0, 16);
        collectAndCheck("verbatim");
    endtask

    task automatic testFixedOrders();
        for (int k = 0; k <= `MAX_ORDER; k++) begin
            clearQueues();
            fillResiduals(20, 64);
            sendBlock(FIXED, orderT'(k), 20);
            collectAndCheck($sformatf("fixedOrder%0d", k));
        end
    endtask

    // the second block must start cold again, whatever the first one left behind.
    task automatic testWarmRestart();
        clearQueues();
        fillResiduals(10, 64);
        sendBlock(FIXED, 3'd3, 10);
        fillResiduals(10, 64);
        sendBlock(FIXED, 3'd3, 10);
        collectAndCheck("warmRestart");
    endtask

    task automatic testBackPressure();
        sampleT freeRun [$];
        clearQueues();
        fillResiduals(24, 64);
        sendBlock(FIXED, 3'd2, 24);
        collectAndCheck("backPressureFree");
        freeRun = gotSamples;
        clearQueues();
        stallEnable = 1'b1; // same words again, with outReady toggling.
        sendBlock(FIXED, 3'd2, 24);
        collectAndCheck("backPressureStalled");
        stallEnable = 1'b0;
        for (int i = 0; i < freeRun.size() && i < gotSamples.size(); i++) begin
            checkSample("backPressureMatch", i, freeRun[i], gotSamples[i]);
        end
    endtask

    task automatic testWrapAround();
        clearQueues();
        fillResiduals(20, 0);
        resWords[0] = 16'sh7000;
        resWords[1] = 16'sh7fff; // the next prediction runs past the top of the range.
        sendBlock(FIXED, 3'd2, 20);
        collectAndCheck("wrapAround");
    endtask

    // ==================================================
    // receiver, watchdog and test sequence.
    // ==================================================

    // outReady is driven on the falling edge and the sample read just after it.
    initial begin
        int r;
        outReady = 1'b0;
        forever begin
            @(negedge iClock);
            r = $random(stallSeed);
            outReady = stallEnable ? r[0] : 1'b1;
            #1;
            if (outValid && outReady) begin // it leaves on the coming rising edge.
                gotSamples.push_back(outSample);
                gotLast.push_back(outLast);
            end
        end
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge iClock);
            cycleCount++;
        end
        $display("timeout: the run passed %0d cycles without finishing", timeoutCycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        inValid     = 1'b0;
        inWord      = '0;
        stallEnable = 1'b0;
        @(posedge rstN);
        @(negedge iClock);
        testConstant();
        testVerbatim();
        testFixedOrders();
        testWarmRestart();
        testBackPressure();
        testWrapAround();
        $display("errors: %0d sample, %0d last flag, %0d sample count, %0d input handshake",
                 sampleErrors, lastErrors, countErrors, readyErrors);
        if (sampleErrors + lastErrors + countErrors + readyErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verification/subframeDecoder_properties.sv ====
`include "flac_config.svh"

// handshake and reset rules of the decoder's two streams.
module subframeDecoderProperties
    import flacStreamPkg::*;
(
    input logic                            iClock,
    input logic                            rstN,
    input logic                            inValid,
    input logic                            inReady,
    input streamWordT                      inWord,
    input logic                            outValid,
    input logic                            outReady,
    input logic signed [`SAMPLE_WIDTH-1:0] outSample,
    input logic                            outLast
);

    // an offered word stays on offer, unchanged, until the decoder takes it.
    inHoldsUntilTaken: assert property (@(posedge iClock) disable iff (!rstN)
        inValid && !inReady |=> inValid && $stable(inWord))
        else $error("input word changed or was withdrawn before it was taken");

    // a stalled output sample keeps its value and its last flag.
    outHoldsUntilTaken: assert property (@(posedge iClock) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outSample) && $stable(outLast))
        else $error("output sample changed or was withdrawn while stalled");

    outQuietInReset: assert property (@(posedge iClock)
        !rstN |-> !outValid)
        else $error("outValid is high while reset is held");

    // the last flag only means something next to a valid sample.
    lastNeedsValid: assert property (@(posedge iClock) disable iff (!rstN)
        outLast |-> outValid)
        else $error("outLast is high without outValid");

endmodule
